// File: design/mcntrl_cmd_pkg.sv
/*
 * command side definitions of the test controller
 * address map, opcode enum, mode bits, channel and frame widths
 */
package mcntrl_cmd_pkg;

    localparam int num_chn = 4;                 // memory channels under test
    localparam int chn_bits = $clog2(num_chn);  // channel index width

    localparam logic [15:0] cmd_base_addr = 16'h00f0;
    localparam logic [15:0] cmd_addr_mask = 16'h07f0;
    localparam int cmd_addr_bits = 4;           // low address bits kept after match

    // channel n: mode at 2+2n, status control at 3+2n
    typedef enum logic [cmd_addr_bits-1:0] {
        chn0_mode   = 4'h2,
        chn0_status = 4'h3,
        chn1_mode   = 4'h4,
        chn1_status = 4'h5,
        chn2_mode   = 4'h6,
        chn2_status = 4'h7,
        chn3_mode   = 4'h8,
        chn3_status = 4'h9
    } cmd_op_e;

    localparam int mode_frame_start_bit = 0;    // bits of the mode data byte
    localparam int mode_next_page_bit = 1;
    localparam int mode_suspend_bit = 2;

    localparam int frame_height_bits = 16;
    typedef logic [frame_height_bits-1:0] line_t;

    localparam int page_bits = 4;
    typedef logic [page_bits-1:0] page_t;       // wraps at 16

endpackage

// File: design/mcntrl_status_pkg.sv
/*
 * status side definitions of the test controller
 * payload layout, status mode enum, packet length
 */
package mcntrl_status_pkg;

    localparam int payload_bits = 26;
    typedef logic [payload_bits-1:0] payload_t;

    localparam int busy_bit = 0;        // payload field positions
    localparam int finished_bit = 1;
    localparam int line_lsb = 2;        // unfinished line in 17:2
    localparam int page_lsb = 18;       // page in 21:18, 25:22 stay zero

    // status control byte: mode in wd[7:6], sequence number in wd[5:0]
    localparam int mode_lsb = 6;
    localparam int seq_bits = 6;

    typedef enum logic [1:0] {
        status_stop   = 2'd0,           // 2'd2 behaves as stop too
        status_single = 2'd1,
        status_auto   = 2'd3
    } status_mode_e;

    localparam logic [7:0] status_reg_base = 8'h3c;  // channel n reports 0x3c+n
    localparam int packet_bytes = 5;    // address byte plus four body bytes

endpackage

// File: design/cmd_deser.sv
/*
 * byte-serial command deserializer
 * address low, address high, data; masked address match, write strobe
 */
`timescale 1ns/1ps

module cmd_deser (
    input  logic                                     mclk,
    input  logic                                     rst,
    input  logic [7:0]                               cmd_ad,
    input  logic                                     cmd_stb,
    output logic                                     cmd_we,
    output logic [mcntrl_cmd_pkg::cmd_addr_bits-1:0] cmd_a,
    output logic [7:0]                               cmd_data
);
    import mcntrl_cmd_pkg::*;

    logic [1:0] byte_cnt;       // 0 idle, 1 expect addr high, 2 expect data
    logic [7:0] addr_lo;
    logic [7:0] addr_hi;
    logic       addr_match;
    logic       data_byte;

    assign addr_match = ((({addr_hi, addr_lo}) ^ cmd_base_addr) & cmd_addr_mask) == 16'h0000;
    assign data_byte  = !cmd_stb && (byte_cnt == 2'd2);  // a new strobe aborts

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            byte_cnt <= 2'd0;
            cmd_we   <= 1'b0;
        end else begin
            cmd_we <= data_byte && addr_match;
            if (cmd_stb) begin
                byte_cnt <= 2'd1;
            end else if (byte_cnt == 2'd2) begin
                byte_cnt <= 2'd0;
            end else if (byte_cnt != 2'd0) begin
                byte_cnt <= byte_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (cmd_stb) begin
            addr_lo <= cmd_ad;
        end
        if (!cmd_stb && (byte_cnt == 2'd1)) begin
            addr_hi <= cmd_ad;
        end
        if (data_byte) begin
            cmd_data <= cmd_ad;
            cmd_a    <= addr_lo[cmd_addr_bits-1:0];  // opcode lives in low nibble
        end
    end

endmodule

// File: design/channel_ctrl.sv
/*
 * per-channel command decode and frame tracking
 * mode pulses, suspend level, page counter, busy and finished flags
 */
`timescale 1ns/1ps

module channel_ctrl #(
    parameter int chn = 0
) (
    input  logic                                     mclk,
    input  logic                                     rst,
    input  logic                                     cmd_we,
    input  logic [mcntrl_cmd_pkg::cmd_addr_bits-1:0] cmd_a,
    input  logic [7:0]                               cmd_data,
    input  logic                                     page_ready,
    input  logic                                     frame_done,
    input  mcntrl_cmd_pkg::line_t                    line_unfinished,
    output logic                                     frame_start,
    output logic                                     next_page,
    output logic                                     suspend,
    output logic                                     status_we,
    output mcntrl_status_pkg::payload_t              payload
);
    import mcntrl_cmd_pkg::*;
    import mcntrl_status_pkg::*;

    localparam cmd_op_e mode_op = cmd_op_e'(int'(chn0_mode) + 2 * chn);
    localparam cmd_op_e status_op = cmd_op_e'(int'(chn0_status) + 2 * chn);

    logic  set_mode;
    page_t page;
    logic  busy;
    logic  finished;

    assign set_mode  = cmd_we && (cmd_a == mode_op);
    assign status_we = cmd_we && (cmd_a == status_op);  // data goes straight to status_gen

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            frame_start <= 1'b0;
            next_page   <= 1'b0;
            suspend     <= 1'b0;
            page        <= '0;
            busy        <= 1'b0;
            finished    <= 1'b0;
        end else begin
            frame_start <= set_mode && cmd_data[mode_frame_start_bit];
            next_page   <= set_mode && cmd_data[mode_next_page_bit];
            if (set_mode) begin
                suspend <= cmd_data[mode_suspend_bit];  // level, held until next mode write
            end
            if (frame_start) begin
                page <= '0;
            end else if (page_ready) begin
                page <= page + 1'b1;
            end
            if (frame_start && !frame_done) begin
                busy     <= 1'b1;
                finished <= 1'b0;
            end else if (!frame_start && frame_done) begin
                busy     <= 1'b0;
                finished <= 1'b1;
            end
        end
    end

    always_comb begin
        payload = '0;                           // unused page bits read as zero
        payload[busy_bit] = busy;
        payload[finished_bit] = finished;
        payload[line_lsb +: frame_height_bits] = line_unfinished;
        payload[page_lsb +: page_bits] = page;
    end

endmodule

// File: design/status_gen.sv
/*
 * per-channel status packet sender
 * stop, single and auto modes, sequence number, rq/start handshake
 */
`timescale 1ns/1ps

module status_gen #(
    parameter logic [7:0] status_addr = mcntrl_status_pkg::status_reg_base
) (
    input  logic                        mclk,
    input  logic                        rst,
    input  logic                        status_we,
    input  logic [7:0]                  wd,
    input  mcntrl_status_pkg::payload_t payload,
    output logic [7:0]                  ad,
    output logic                        rq,
    input  logic                        start
);
    import mcntrl_status_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_req,                             // rq high, address byte on ad
        st_send                             // four body bytes
    } state_e;

    state_e              state;
    status_mode_e        mode;
    status_mode_e        wd_mode;
    logic [seq_bits-1:0] seq;
    payload_t            sent;              // payload of the last packet
    logic [1:0]          byte_cnt;
    logic                pend;              // request written during a send
    logic                wr_req;
    logic                changed;
    logic                last_byte;

    assign wd_mode   = status_mode_e'(wd[mode_lsb +: 2]);
    assign wr_req    = status_we && ((wd_mode == status_single) || (wd_mode == status_auto));
    assign changed   = (mode == status_auto) && (payload != sent);
    assign last_byte = byte_cnt == 2'(packet_bytes - 2);
    assign rq        = state == st_req;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            mode <= status_stop;
            seq  <= '0;
        end else if (status_we) begin
            mode <= wd_mode;
            seq  <= wd[seq_bits-1:0];
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            byte_cnt <= 2'd0;
            pend     <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (wr_req || changed) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (start) begin
                        state    <= st_send;
                        byte_cnt <= 2'd0;
                    end
                end
                st_send: begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (last_byte) begin
                        state <= (pend || wr_req || changed) ? st_req : st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
            pend <= (state == st_send) && !last_byte && (pend || wr_req);
        end
    end

    always_ff @(posedge mclk) begin
        if ((state == st_req) && start) begin
            sent <= payload;                // snapshot at start
        end
    end

    always_comb begin
        if (state != st_send) begin
            ad = status_addr;
        end else begin
            case (byte_cnt)
                2'd0:    ad = {seq, sent[1:0]};
                2'd1:    ad = sent[9:2];
                2'd2:    ad = sent[17:10];
                default: ad = sent[payload_bits-1 -: 8];
            endcase
        end
    end

endmodule

// File: design/status_router.sv
/*
 * round-robin status router
 * merges the per-channel packet streams onto one rq/start link
 */
`timescale 1ns/1ps

module status_router (
    input  logic                                      mclk,
    input  logic                                      rst,
    input  logic [mcntrl_cmd_pkg::num_chn-1:0][7:0]   in_ad,
    input  logic [mcntrl_cmd_pkg::num_chn-1:0]        in_rq,
    output logic [mcntrl_cmd_pkg::num_chn-1:0]        in_start,
    output logic [7:0]                                status_ad,
    output logic                                      status_rq,
    input  logic                                      status_start
);
    import mcntrl_cmd_pkg::*;
    import mcntrl_status_pkg::*;

    typedef enum logic [1:0] {
        rt_idle,
        rt_req,                             // granted, waiting for status_start
        rt_send
    } state_e;

    state_e              state;
    logic [chn_bits-1:0] gnt;               // current or last granted channel
    logic [chn_bits-1:0] nxt;
    logic [chn_bits-1:0] idx;
    logic                found;
    logic [1:0]          byte_cnt;          // body bytes passed

    // search starts one past the last grant
    always_comb begin
        nxt   = gnt;
        found = 1'b0;
        idx   = gnt;
        for (int i = 1; i <= num_chn; i++) begin
            idx = gnt + chn_bits'(i);       // wraps, num_chn is a power of two
            if (!found && in_rq[idx]) begin
                nxt   = idx;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state    <= rt_idle;
            gnt      <= chn_bits'(num_chn - 1);  // channel 0 wins first
            byte_cnt <= 2'd0;
        end else begin
            case (state)
                rt_idle: begin
                    if (found) begin
                        gnt   <= nxt;
                        state <= rt_req;
                    end
                end
                rt_req: begin
                    if (status_start) begin
                        state    <= rt_send;
                        byte_cnt <= 2'd0;
                    end
                end
                rt_send: begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (byte_cnt == 2'(packet_bytes - 2)) begin
                        state <= rt_idle;    // grant released after last byte
                    end
                end
                default: state <= rt_idle;
            endcase
        end
    end

    assign status_rq = state == rt_req;
    assign status_ad = in_ad[gnt];

    always_comb begin
        in_start = '0;
        if (state == rt_req) begin
            in_start[gnt] = status_start;   // only the granted sender sees start
        end
    end

endmodule

// File: design/mcntrl_test01.sv
/*
 * four-channel memory test controller, top level
 * command deserializer, channel controls, status senders and router
 */
`timescale 1ns/1ps

module mcntrl_test01 (
    input  logic                                                  mclk,
    input  logic                                                  rst,
    input  logic [7:0]                                            cmd_ad,
    input  logic                                                  cmd_stb,
    output logic [7:0]                                            status_ad,
    output logic                                                  status_rq,
    input  logic                                                  status_start,
    output logic [mcntrl_cmd_pkg::num_chn-1:0]                    frame_start,
    output logic [mcntrl_cmd_pkg::num_chn-1:0]                    next_page,
    output logic [mcntrl_cmd_pkg::num_chn-1:0]                    suspend,
    input  logic [mcntrl_cmd_pkg::num_chn-1:0]                    page_ready,
    input  logic [mcntrl_cmd_pkg::num_chn-1:0]                    frame_done,
    input  mcntrl_cmd_pkg::line_t [mcntrl_cmd_pkg::num_chn-1:0]   line_unfinished
);
    import mcntrl_cmd_pkg::*;
    import mcntrl_status_pkg::*;

    logic                     cmd_we;
    logic [cmd_addr_bits-1:0] cmd_a;
    logic [7:0]               cmd_data;
    logic [num_chn-1:0]       status_we;
    payload_t [num_chn-1:0]   payload;
    logic [num_chn-1:0][7:0]  chn_ad;       // per-channel status links
    logic [num_chn-1:0]       chn_rq;
    logic [num_chn-1:0]       chn_start;

    cmd_deser cmd_deser_i (
        .mclk     (mclk),
        .rst      (rst),
        .cmd_ad   (cmd_ad),
        .cmd_stb  (cmd_stb),
        .cmd_we   (cmd_we),
        .cmd_a    (cmd_a),
        .cmd_data (cmd_data)
    );

    for (genvar n = 0; n < num_chn; n++) begin : g_chn
        channel_ctrl #(
            .chn (n)
        ) channel_ctrl_i (
            .mclk            (mclk),
            .rst             (rst),
            .cmd_we          (cmd_we),
            .cmd_a           (cmd_a),
            .cmd_data        (cmd_data),
            .page_ready      (page_ready[n]),
            .frame_done      (frame_done[n]),
            .line_unfinished (line_unfinished[n]),
            .frame_start     (frame_start[n]),
            .next_page       (next_page[n]),
            .suspend         (suspend[n]),
            .status_we       (status_we[n]),
            .payload         (payload[n])
        );

        status_gen #(
            .status_addr (8'(status_reg_base + n))
        ) status_gen_i (
            .mclk      (mclk),
            .rst       (rst),
            .status_we (status_we[n]),
            .wd        (cmd_data),
            .payload   (payload[n]),
            .ad        (chn_ad[n]),
            .rq        (chn_rq[n]),
            .start     (chn_start[n])
        );
    end

    status_router status_router_i (
        .mclk         (mclk),
        .rst          (rst),
        .in_ad        (chn_ad),
        .in_rq        (chn_rq),
        .in_start     (chn_start),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

endmodule

// File: sim/mcntrl_test01_checker.sv
/*
 * concurrent assertions on the test controller top level
 * one frame start at a time, quiet status_rq in packet body, single-cycle pulses
 */
`timescale 1ns/1ps

module mcntrl_test01_checker (
    input logic                               mclk,
    input logic                               rst,
    input logic [mcntrl_cmd_pkg::num_chn-1:0] frame_start,
    input logic [mcntrl_cmd_pkg::num_chn-1:0] next_page,
    input logic                               status_rq,
    input logic                               status_start
);
    logic start_seen;

    assign start_seen = status_rq && status_start;  // address byte taken

    frame_start_one_chn: assert property (@(posedge mclk) disable iff (rst)
        $onehot0(frame_start))
        else $error("frame_start high on more than one channel");

    // four body bytes follow the start cycle
    no_rq_in_body: assert property (@(posedge mclk) disable iff (rst)
        ($past(start_seen, 1) || $past(start_seen, 2) ||
         $past(start_seen, 3) || $past(start_seen, 4)) |-> !status_rq)
        else $error("status_rq high during the body of a status packet");

    frame_start_single: assert property (@(posedge mclk) disable iff (rst)
        (frame_start & $past(frame_start)) == '0)
        else $error("frame_start high two cycles in a row");

    next_page_single: assert property (@(posedge mclk) disable iff (rst)
        (next_page & $past(next_page)) == '0)
        else $error("next_page high two cycles in a row");

endmodule

bind mcntrl_test01 mcntrl_test01_checker checker_i (
    .mclk         (mclk),
    .rst          (rst),
    .frame_start  (frame_start),
    .next_page    (next_page),
    .status_rq    (status_rq),
    .status_start (status_start)
);

// File: sim/tb_mcntrl_test01.sv
/*
 * testbench for the four-channel test controller
 * clock, reset, LFSR, check task, directed tests, watchdog
 */
`timescale 1ns/1ps

module tb_mcntrl_test01;
    import mcntrl_cmd_pkg::*;

    localparam int clk_period = 20;
    localparam int reset_cycles = 8;
    localparam logic [15:0] cmd_block = 16'h00f0;   // matched command block
    localparam logic [7:0] report_base = 8'h3c;     // channel n reports 0x3c+n
    localparam int packet_len = 5;
    localparam int rq_wait_limit = 16;
    localparam int pulse_cycles = 80;               // rough test lengths
    localparam int foreign_cycles = 40;
    localparam int suspend_cycles = 80;
    localparam int single_cycles = 400;
    localparam int auto_cycles = 100;
    localparam int stop_cycles = 80;
    localparam int margin_cycles = 200;
    localparam int run_cycles = reset_cycles + pulse_cycles + foreign_cycles +
        suspend_cycles + single_cycles + auto_cycles + stop_cycles + margin_cycles;

    logic                mclk = 1'b0;
    logic                rst;
    logic [7:0]          cmd_ad;
    logic                cmd_stb;
    logic [7:0]          status_ad;
    logic                status_rq;
    logic                status_start;
    logic [num_chn-1:0]  frame_start;
    logic [num_chn-1:0]  next_page;
    logic [num_chn-1:0]  suspend;
    logic [num_chn-1:0]  page_ready;
    logic [num_chn-1:0]  frame_done;
    line_t [num_chn-1:0] line_unfinished;

    logic [15:0] lfsr = 16'd37;
    int          errors = 0;
    logic [7:0]  pkt [packet_len];                  // last packet read
    int          last_grant;                        // expected router state
    page_t       model_page [num_chn];
    logic        model_busy [num_chn];
    logic        model_fin [num_chn];
    logic [5:0]  model_seq [num_chn];

    always #(clk_period / 2) mclk = ~mclk;

    mcntrl_test01 mcntrl_test01_i (
        .mclk            (mclk),
        .rst             (rst),
        .cmd_ad          (cmd_ad),
        .cmd_stb         (cmd_stb),
        .status_ad       (status_ad),
        .status_rq       (status_rq),
        .status_start    (status_start),
        .frame_start     (frame_start),
        .next_page       (next_page),
        .suspend         (suspend),
        .page_ready      (page_ready),
        .frame_done      (frame_done),
        .line_unfinished (line_unfinished)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            fail_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                               name, actual, expected));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic random_bits(input int nbits, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[14:0], lfsr[0]};         // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [15:0] mode_cmd_addr(input int n);
        return cmd_block | 16'(2 + 2 * n);
    endfunction

    function automatic logic [15:0] status_cmd_addr(input int n);
        return cmd_block | 16'(3 + 2 * n);
    endfunction

    // next requester after the last grant
    function automatic int rr_pick(input int last, input logic [num_chn-1:0] mask);
        int c;
        for (int i = 1; i <= num_chn; i++) begin
            c = (last + i) % num_chn;
            if (mask[c]) begin
                return c;
            end
        end
        return -1;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge mclk);
    endtask

    task automatic send_cmd(input logic [15:0] addr, input logic [7:0] data);
        cmd_stb = 1'b1;
        cmd_ad  = addr[7:0];
        @(negedge mclk);
        cmd_stb = 1'b0;
        cmd_ad  = addr[15:8];
        @(negedge mclk);
        cmd_ad = data;
        @(negedge mclk);
        cmd_ad = 8'h00;                             // cmd_we is high now
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge mclk);
            check_value("frame_start", frame_start, 0);
            check_value("next_page", next_page, 0);
            check_value("suspend", suspend, 0);
            check_value("status_rq", status_rq, 0);
        end
    endtask

    task automatic read_packet(input int hold);
        int waited;
        waited = 0;
        while (!status_rq) begin
            if (waited == rq_wait_limit) begin
                fail_run("status_rq did not rise for an expected status packet");
            end
            @(negedge mclk);
            waited++;
        end
        repeat (hold) begin
            @(negedge mclk);
            check_value("status_rq", status_rq, 1);  // start withheld
        end
        status_start = 1'b1;
        pkt[0] = status_ad;
        for (int i = 1; i < packet_len; i++) begin
            @(negedge mclk);
            status_start = 1'b0;
            pkt[i] = status_ad;
        end
    endtask

    task automatic check_packet(input int n);
        check_value("status_ad addr", pkt[0], report_base + 8'(n));
        check_value("status_ad seq", pkt[1], {model_seq[n], model_fin[n], model_busy[n]});
        check_value("status_ad line lo", pkt[2], line_unfinished[n][7:0]);
        check_value("status_ad line hi", pkt[3], line_unfinished[n][15:8]);
        check_value("status_ad page", pkt[4], {4'h0, model_page[n]});
        last_grant = n;
    endtask

    task automatic mode_pulse(input int n, input int bit_idx);
        logic [num_chn-1:0] onehot;
        onehot = '0;
        onehot[n] = 1'b1;
        send_cmd(mode_cmd_addr(n), 8'(1 << bit_idx));
        check_value("frame_start", frame_start, 0);
        check_value("next_page", next_page, 0);
        @(negedge mclk);
        check_value("frame_start", frame_start, (bit_idx == 0) ? onehot : 4'b0);
        check_value("next_page", next_page, (bit_idx == 1) ? onehot : 4'b0);
        @(negedge mclk);
        check_value("frame_start", frame_start, 0);
        check_value("next_page", next_page, 0);
        if (bit_idx == 0) begin
            model_page[n] = '0;
            model_busy[n] = 1'b1;
            model_fin[n]  = 1'b0;
        end
    endtask

    task automatic reset_and_pulses();
        check_value("frame_start", frame_start, 0);
        check_value("next_page", next_page, 0);
        check_value("suspend", suspend, 0);
        check_value("status_rq", status_rq, 0);
        for (int n = 0; n < num_chn; n++) begin
            mode_pulse(n, 0);                       // frame start bit
            mode_pulse(n, 1);                       // next page bit
        end
    endtask

    task automatic foreign_address();
        send_cmd(16'h01f2, 8'h07);                  // bit 8 differs inside the mask
        expect_quiet(4);
        send_cmd(16'h0173, 8'h40);
        expect_quiet(6);
        send_cmd(16'h0002, 8'h01);
        expect_quiet(4);
    endtask

    task automatic suspend_level();
        logic [num_chn-1:0] onehot;
        for (int n = 0; n < num_chn; n++) begin
            onehot = '0;
            onehot[n] = 1'b1;
            send_cmd(mode_cmd_addr(n), 8'h04);
            check_value("suspend", suspend, 0);
            repeat (4) begin
                @(negedge mclk);
                check_value("suspend", suspend, onehot);
                check_value("frame_start", frame_start, 0);
            end
            send_cmd(mode_cmd_addr(n), 8'h00);
            check_value("suspend", suspend, onehot);
            @(negedge mclk);
            check_value("suspend", suspend, 0);
        end
    endtask

    task automatic single_status(input int n);
        logic [15:0] r;
        int          k;
        mode_pulse(n, 0);
        random_bits(5, r);
        k = int'(r);
        for (int i = 0; i < k; i++) begin
            page_ready[n] = 1'b1;
            @(negedge mclk);
            page_ready[n] = 1'b0;
            @(negedge mclk);
        end
        model_page[n] = page_t'(k % 16);            // counter wraps at 16
        random_bits(16, r);
        line_unfinished[n] = r;
        random_bits(6, r);
        model_seq[n] = r[5:0];
        send_cmd(status_cmd_addr(n), {2'b01, model_seq[n]});
        read_packet(0);
        check_packet(n);
        frame_done[n] = 1'b1;
        @(negedge mclk);
        frame_done[n] = 1'b0;
        @(negedge mclk);
        model_busy[n] = 1'b0;
        model_fin[n]  = 1'b1;
        model_seq[n]  = model_seq[n] + 6'd1;
        send_cmd(status_cmd_addr(n), {2'b01, model_seq[n]});
        read_packet(0);
        check_packet(n);
    endtask

    task automatic auto_round_robin();
        logic [15:0]        r;
        logic [num_chn-1:0] rest;
        int                 first;
        int                 second;
        for (int n = 2; n >= 1; n--) begin          // channel 1 granted last
            random_bits(6, r);
            model_seq[n] = r[5:0];
            send_cmd(status_cmd_addr(n), {2'b11, model_seq[n]});
            read_packet(0);                         // auto write sends at once
            check_packet(n);
        end
        rest = 4'b0110;
        first = rr_pick(last_grant, rest);
        rest[first] = 1'b0;
        second = rr_pick(first, rest);
        random_bits(16, r);
        line_unfinished[1] = r;
        random_bits(16, r);
        line_unfinished[2] = r;                     // same edge as channel 1
        read_packet(5);
        check_packet(first);
        read_packet(0);
        check_packet(second);
    endtask

    task automatic stop_mode();
        logic [15:0] r;
        send_cmd(status_cmd_addr(1), 8'h00);
        send_cmd(status_cmd_addr(2), 8'h80);        // mode 2 acts as stop
        idle_cycles(2);
        random_bits(16, r);
        line_unfinished[1] = r;
        random_bits(16, r);
        line_unfinished[2] = r;
        page_ready[2] = 1'b1;
        @(negedge mclk);
        page_ready[2] = 1'b0;
        expect_quiet(20);
    endtask

    initial begin
        rst             = 1'b1;
        cmd_ad          = 8'h00;
        cmd_stb         = 1'b0;
        status_start    = 1'b0;
        page_ready      = '0;
        frame_done      = '0;
        line_unfinished = '0;
        last_grant      = num_chn - 1;              // channel 0 is granted first
        for (int n = 0; n < num_chn; n++) begin
            model_page[n] = '0;
            model_busy[n] = 1'b0;
            model_fin[n]  = 1'b0;
            model_seq[n]  = '0;
        end
        idle_cycles(reset_cycles);
        rst = 1'b0;
        @(negedge mclk);
        reset_and_pulses();
        foreign_address();
        suspend_level();
        for (int n = 0; n < num_chn; n++) begin
            single_status(n);
        end
        auto_round_robin();
        stop_mode();
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(run_cycles * clk_period);
        fail_run("run timed out before all tests finished");
    end

endmodule

// File: filelist.f
design/mcntrl_cmd_pkg.sv
design/mcntrl_status_pkg.sv
design/cmd_deser.sv
design/channel_ctrl.sv
design/status_gen.sv
design/status_router.sv
design/mcntrl_test01.sv
sim/mcntrl_test01_checker.sv
sim/tb_mcntrl_test01.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal --top-module tb_mcntrl_test01 \
    -f filelist.f -o tb_mcntrl_test01 &&
./obj_dir/tb_mcntrl_test01 | tee /dev/stderr | grep -qxF "All tests passed!" &&
echo "simulation PASSED" ||
{ echo "simulation FAILED"; exit 1; }
